/* src/pn_config.svh */
// Single-precision format constants
// Widths and limits shared by the post-normalisation pipeline
// and its testbench

`ifndef PN_CONFIG_SVH
`define PN_CONFIG_SVH

// Biased exponent field width
`define PN_EXP_W 8

// Unnormalised fraction from the add/subtract datapath
`define PN_FRACT_IN_W 48

// Stored mantissa, hidden bit excluded
`define PN_MANT_W 23

// Leading-zero count, wide enough to hold 48
`define PN_LZ_W 6

// Largest exponent field of a finite number
`define PN_EXP_MAX 254

// Position of the hidden one once the fraction is normalised
`define PN_HIDDEN_BIT 46

`endif

/* src/pn_pkg.sv */
// Post-normalisation package
// Rounding-mode encoding and the payloads carried between
// the pipeline stages

`default_nettype none

`include "pn_config.svh"

package pn_pkg;

	// ------------------------------------------------------------
	// Rounding mode, same encoding as the FPU rmode input
	typedef enum logic [1:0]
	{
		RM_NEAREST_EVEN = 2'd0,
		RM_TO_ZERO      = 2'd1,
		RM_TO_POS_INF   = 2'd2,
		RM_TO_NEG_INF   = 2'd3
	} rmode_t;

	// ------------------------------------------------------------
	// Stage 1 to stage 2
	// Raw operand plus its leading-zero count
	typedef struct packed
	{
		logic [`PN_EXP_W-1:0]      exp_in;
		logic [`PN_FRACT_IN_W-1:0] fract_in;
		logic [`PN_LZ_W-1:0]       lz;
	} lzc_payload_t;

	// ------------------------------------------------------------
	// Stage 2 to stage 3
	// Exponent is 0 for a denormal, mant holds the hidden bit on top
	typedef struct packed
	{
		logic signed [`PN_EXP_W:0] exp_norm;
		logic [`PN_MANT_W:0]       mant;
		logic                      guard;
		logic                      sticky;
	} norm_payload_t;

endpackage

`default_nettype wire

/* src/pn_stream_if.sv */
// Valid/ready stream between pipeline stages
// Carries sign and rounding mode beside a typed payload

`timescale 1ns/100ps
`default_nettype none

interface pn_stream_if #(
	parameter type T = logic
);

	logic           valid;
	logic           ready;
	logic           sign;
	pn_pkg::rmode_t rmode;
	T               payload;

	// Producer side
	modport src
	(
		output valid,
		output sign,
		output rmode,
		output payload,
		input  ready
	);

	// Consumer side
	modport dst
	(
		input  valid,
		input  sign,
		input  rmode,
		input  payload,
		output ready
	);

endinterface

`default_nettype wire

/* src/pn_pipe_reg.sv */
// Pipeline register for one stream stage
// Holds one item; accepts a new one when empty or when the
// downstream side takes the current one in the same cycle

`timescale 1ns/100ps
`default_nettype none

module pn_pipe_reg #(
	parameter type T = logic
) (
	input  wire      clk,
	input  wire      rst_n,
	pn_stream_if.dst up,
	pn_stream_if.src dn
);

	logic           valid_q;
	logic           sign_q;
	pn_pkg::rmode_t rmode_q;
	T               payload_q;
	logic           load;

	// Free slot, or the held item leaves this cycle
	assign up.ready = !valid_q || dn.ready;
	assign load = up.valid && up.ready;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			valid_q <= 1'b0;
		else if (up.ready)
			valid_q <= up.valid;
	end

	// Data only moves on an accepted transfer
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			sign_q    <= up.sign;
			rmode_q   <= up.rmode;
			payload_q <= up.payload;
		end
	end

	assign dn.valid   = valid_q;
	assign dn.sign    = sign_q;
	assign dn.rmode   = rmode_q;
	assign dn.payload = payload_q;

endmodule

`default_nettype wire

/* src/pn_lzc_stage.sv */
// Stage 1 of post-normalisation
// Counts the leading zeros of the raw fraction from its top bit

`timescale 1ns/100ps
`default_nettype none

`include "pn_config.svh"

module pn_lzc_stage (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      in_valid,
	output logic                     in_ready,
	input  wire                      in_sign,
	input  wire pn_pkg::rmode_t      in_rmode,
	input  wire [`PN_EXP_W-1:0]      in_exp,
	input  wire [`PN_FRACT_IN_W-1:0] in_fract,
	pn_stream_if.src                 o
);

	localparam int LZ_W = `PN_LZ_W;

	pn_pkg::lzc_payload_t pl;

	pn_stream_if #(.T(pn_pkg::lzc_payload_t)) s ();

	// ------------------------------------------------------------
	// Leading-zero count
	// Scan upward so the highest set bit sets the count last;
	// an all-zero fraction keeps the full width
	always_comb
	begin
		pl.exp_in   = in_exp;
		pl.fract_in = in_fract;
		pl.lz       = LZ_W'(`PN_FRACT_IN_W);
		for (int b = 0; b < `PN_FRACT_IN_W; b++)
		begin
			if (in_fract[b])
				pl.lz = LZ_W'(`PN_FRACT_IN_W - 1 - b);
		end
	end

	// ------------------------------------------------------------
	// Into the stage register
	assign s.valid   = in_valid;
	assign s.sign    = in_sign;
	assign s.rmode   = in_rmode;
	assign s.payload = pl;
	assign in_ready  = s.ready;

	pn_pipe_reg #(.T(pn_pkg::lzc_payload_t)) u_reg (
		.clk   (clk),
		.rst_n (rst_n),
		.up    (s),
		.dn    (o)
	);

endmodule

`default_nettype wire

/* src/pn_shift_stage.sv */
// Stage 2 of post-normalisation
// Shifts the fraction to normal or denormal position, adjusts the
// exponent and splits off the guard and sticky bits

`timescale 1ns/100ps
`default_nettype none

`include "pn_config.svh"

module pn_shift_stage (
	input  wire      clk,
	input  wire      rst_n,
	pn_stream_if.dst i,
	pn_stream_if.src o
);

	localparam int EW = `PN_EXP_W + 1;
	localparam int GUARD_BIT = `PN_HIDDEN_BIT - `PN_MANT_W - 1;

	logic [EW-1:0]              exp_eff;
	logic [EW-1:0]              lz_m1;
	logic [EW-1:0]              shl;
	logic [EW-1:0]              exp_sh;
	logic [`PN_FRACT_IN_W-1:0]  shifted;
	logic                       lost;
	pn_pkg::lzc_payload_t       pin;
	pn_pkg::norm_payload_t      pl;

	pn_stream_if #(.T(pn_pkg::norm_payload_t)) n ();

	assign pin = i.payload;

	// A zero exponent field weighs like exponent 1
	assign exp_eff = (pin.exp_in == '0) ? EW'(1) : EW'(pin.exp_in);
	assign lz_m1   = EW'(pin.lz) - EW'(1);

	// ------------------------------------------------------------
	// Shift select
	always_comb
	begin
		shl = '0;
		if (pin.fract_in[`PN_FRACT_IN_W-1])
		begin
			// Carry out of the add, one place right
			shifted = pin.fract_in >> 1;
			lost    = pin.fract_in[0];
			exp_sh  = exp_eff + EW'(1);
		end
		else
		begin
			// Stop at exponent 1 so small values end up denormal
			shl     = (lz_m1 < exp_eff - EW'(1)) ? lz_m1 : exp_eff - EW'(1);
			shifted = pin.fract_in << shl;
			lost    = 1'b0;
			exp_sh  = exp_eff - shl;
		end
		// 256 is out of range either way, 255 overflows all the same
		if (exp_sh[EW-1])
			exp_sh = EW'(255);
	end

	// ------------------------------------------------------------
	// Output fields
	always_comb
	begin
		pl.exp_norm = shifted[`PN_HIDDEN_BIT] ? exp_sh : '0;
		pl.mant     = shifted[`PN_HIDDEN_BIT:`PN_HIDDEN_BIT-`PN_MANT_W];
		pl.guard    = shifted[GUARD_BIT];
		pl.sticky   = (|shifted[GUARD_BIT-1:0]) | lost;
	end

	assign n.valid   = i.valid;
	assign n.sign    = i.sign;
	assign n.rmode   = i.rmode;
	assign n.payload = pl;
	assign i.ready   = n.ready;

	pn_pipe_reg #(.T(pn_pkg::norm_payload_t)) u_reg (
		.clk   (clk),
		.rst_n (rst_n),
		.up    (n),
		.dn    (o)
	);

endmodule

`default_nettype wire

/* src/pn_round_stage.sv */
// Stage 3 of post-normalisation
// Rounds in the selected mode, handles overflow to infinity or
// the largest finite value, and packs the IEEE word with flags

`timescale 1ns/100ps
`default_nettype none

`include "pn_config.svh"

module pn_round_stage (
	input  wire                                  clk,
	input  wire                                  rst_n,
	pn_stream_if.dst                             i,
	output logic                                 out_valid,
	input  wire                                  out_ready,
	output logic [`PN_EXP_W+`PN_MANT_W:0]        out_result,
	output logic                                 out_overflow,
	output logic                                 out_underflow,
	output logic                                 out_inexact
);

	localparam int EXP_W = `PN_EXP_W;
	localparam int SUM_W = `PN_EXP_W + `PN_MANT_W + 1;

	// Magnitude only, the sign rides in the stream itself
	typedef struct packed
	{
		logic [`PN_EXP_W+`PN_MANT_W-1:0] mag;
		logic                            overflow;
		logic                            underflow;
		logic                            inexact;
	} res_t;

	pn_pkg::norm_payload_t pin;
	res_t                  pl;
	logic                  lost;
	logic                  inc;
	logic                  ovf;
	logic                  to_inf;
	logic [SUM_W-1:0]      rnd_sum;

	pn_stream_if #(.T(res_t)) r ();
	pn_stream_if #(.T(res_t)) q ();

	assign pin  = i.payload;
	assign lost = pin.guard | pin.sticky;

	// ------------------------------------------------------------
	// Round increment
	always_comb
	begin
		case (i.rmode)
			pn_pkg::RM_NEAREST_EVEN:
				inc = pin.guard & (pin.sticky | pin.mant[0]);
			pn_pkg::RM_TO_ZERO:
				inc = 1'b0;
			pn_pkg::RM_TO_POS_INF:
				inc = lost & !i.sign;
			default:
				inc = lost & i.sign;
		endcase
	end

	// Mantissa carry spills into the exponent, which also takes a
	// denormal up to the smallest normal
	assign rnd_sum = {pin.exp_norm, pin.mant[`PN_MANT_W-1:0]} + SUM_W'(inc);

	// ------------------------------------------------------------
	// Overflow
	assign ovf = rnd_sum[SUM_W-1:`PN_MANT_W] > `PN_EXP_MAX;

	// Infinity unless the mode rounds toward zero for this sign
	assign to_inf = (i.rmode == pn_pkg::RM_NEAREST_EVEN)
		|| (i.rmode == pn_pkg::RM_TO_POS_INF && !i.sign)
		|| (i.rmode == pn_pkg::RM_TO_NEG_INF && i.sign);

	always_comb
	begin
		if (ovf && to_inf)
			pl.mag = {{`PN_EXP_W{1'b1}}, {`PN_MANT_W{1'b0}}};
		else if (ovf)
			pl.mag = {EXP_W'(`PN_EXP_MAX), {`PN_MANT_W{1'b1}}};
		else
			pl.mag = rnd_sum[SUM_W-2:0];
		pl.overflow  = ovf;
		pl.underflow = (pin.exp_norm == '0) && lost;
		pl.inexact   = lost | ovf;
	end

	assign r.valid   = i.valid;
	assign r.sign    = i.sign;
	assign r.rmode   = i.rmode;
	assign r.payload = pl;
	assign i.ready   = r.ready;

	pn_pipe_reg #(.T(res_t)) u_reg (
		.clk   (clk),
		.rst_n (rst_n),
		.up    (r),
		.dn    (q)
	);

	// ------------------------------------------------------------
	// Result port
	assign out_valid     = q.valid;
	assign q.ready       = out_ready;
	assign out_result    = {q.sign, q.payload.mag};
	assign out_overflow  = q.payload.overflow;
	assign out_underflow = q.payload.underflow;
	assign out_inexact   = q.payload.inexact;

endmodule

`default_nettype wire

/* src/pn_top.sv */
// Floating-point post-normalisation and rounding unit
// Three-stage pipeline: leading-zero count, normalising shift,
// then rounding and packing into an IEEE single-precision word

`timescale 1ns/100ps
`default_nettype none

`include "pn_config.svh"

module pn_top (
	input  wire                             clk,
	input  wire                             rst_n,
	// Unnormalised operand
	input  wire                             in_valid,
	output logic                            in_ready,
	input  wire                             in_sign,
	input  wire pn_pkg::rmode_t             in_rmode,
	input  wire [`PN_EXP_W-1:0]             in_exp,
	input  wire [`PN_FRACT_IN_W-1:0]        in_fract,
	// Packed result and exception flags
	output logic                            out_valid,
	input  wire                             out_ready,
	output logic [`PN_EXP_W+`PN_MANT_W:0]   out_result,
	output logic                            out_overflow,
	output logic                            out_underflow,
	output logic                            out_inexact
);

	pn_stream_if #(.T(pn_pkg::lzc_payload_t))  lzc_s ();
	pn_stream_if #(.T(pn_pkg::norm_payload_t)) norm_s ();

	// ------------------------------------------------------------
	// Stage 1
	pn_lzc_stage u_lzc (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_sign  (in_sign),
		.in_rmode (in_rmode),
		.in_exp   (in_exp),
		.in_fract (in_fract),
		.o        (lzc_s)
	);

	// Stage 2
	pn_shift_stage u_shift (
		.clk   (clk),
		.rst_n (rst_n),
		.i     (lzc_s),
		.o     (norm_s)
	);

	// Stage 3
	pn_round_stage u_round (
		.clk           (clk),
		.rst_n         (rst_n),
		.i             (norm_s),
		.out_valid     (out_valid),
		.out_ready     (out_ready),
		.out_result    (out_result),
		.out_overflow  (out_overflow),
		.out_underflow (out_underflow),
		.out_inexact   (out_inexact)
	);

endmodule

`default_nettype wire

/* tests/pn_ref_model.svh */
// Reference model for the post-normalisation unit
// Rounds the exact operand value to single precision per IEEE-754,
// working on the value itself rather than on the pipeline stages

`ifndef PN_REF_MODEL_SVH
`define PN_REF_MODEL_SVH

// Index of the highest set bit, -1 for an all-zero fraction
function automatic int msb_position(input logic [`PN_FRACT_IN_W-1:0] fract);
	int pos;

	pos = -1;
	for (int b = `PN_FRACT_IN_W - 1; b >= 0; b--)
	begin
		if (fract[b] && pos < 0)
			pos = b;
	end
	return pos;
endfunction

// Whether the discarded part moves the magnitude up by one unit
function automatic logic rounds_up(
	input logic           sign,
	input pn_pkg::rmode_t rmode,
	input logic [63:0]    kept,
	input logic [63:0]    rest,
	input logic [63:0]    half
);
	if (rest == 64'd0)
		return 1'b0;
	case (rmode)
		pn_pkg::RM_NEAREST_EVEN:
			return (rest > half) || (rest == half && kept[0]);
		pn_pkg::RM_TO_ZERO:
			return 1'b0;
		pn_pkg::RM_TO_POS_INF:
			return !sign;
		default:
			return sign;
	endcase
endfunction

// Expected {result, overflow, underflow, inexact} for one operand
function automatic logic [34:0] expected_output(
	input logic                      sign,
	input pn_pkg::rmode_t            rmode,
	input logic [`PN_EXP_W-1:0]      exp_in,
	input logic [`PN_FRACT_IN_W-1:0] fract
);
	int          e;
	int          p;
	int          q;
	int          big_e;
	logic [63:0] kept;
	logic [63:0] rest;
	logic [63:0] half;
	logic        denorm;
	logic        inexact;
	logic        to_inf;
	logic [30:0] mag;

	if (fract == '0)
		return {sign, 31'd0, 3'b000};

	// Operand is fract * 2^(e - 127 - 46)
	e = (exp_in == '0) ? 1 : int'(exp_in);
	p = msb_position(fract);

	// Weight of one unit in the last place, as a bit index of fract;
	// never finer than the smallest denormal step
	q = (p - 23 > 24 - e) ? p - 23 : 24 - e;
	if (q > 0)
	begin
		kept = 64'(fract) >> q;
		rest = 64'(fract) & ((64'd1 << q) - 64'd1);
		half = 64'd1 << (q - 1);
	end
	else
	begin
		kept = 64'(fract) << (-q);
		rest = 64'd0;
		half = 64'd0;
	end
	big_e = q + e - 23;

	denorm  = (kept < 64'h80_0000);
	inexact = (rest != 64'd0);
	if (rounds_up(sign, rmode, kept, rest, half))
		kept = kept + 64'd1;
	if (kept >= 64'h100_0000)
	begin
		kept  = kept >> 1;
		big_e = big_e + 1;
	end

	if (big_e > `PN_EXP_MAX)
	begin
		to_inf = (rmode == pn_pkg::RM_NEAREST_EVEN)
			|| (rmode == pn_pkg::RM_TO_POS_INF && !sign)
			|| (rmode == pn_pkg::RM_TO_NEG_INF && sign);
		mag = to_inf ? 31'h7f80_0000 : 31'h7f7f_ffff;
		return {sign, mag, 3'b101};
	end

	// Below the hidden-bit weight the exponent field stays 0
	if (kept < 64'h80_0000)
		mag = 31'(kept);
	else
		mag = {8'(big_e), kept[22:0]};
	return {sign, mag, 1'b0, denorm && inexact, inexact};
endfunction

`endif

/* tests/tb_pn_top.sv */
// Testbench for the post-normalisation unit
// Random operands in all rounding modes against a reference model,
// with back-pressure, ordering and latency checks

`timescale 1ns/100ps
`default_nettype none

`include "pn_config.svh"

module tb_pn_top;

	localparam int N_NORMAL  = 400;
	localparam int N_DENORM  = 200;
	localparam int N_OVF     = 120;
	localparam int N_ZERO    = 40;
	localparam int N_STALL   = 400;
	localparam int N_LATENCY = 100;
	localparam int N_ITEMS   = N_NORMAL + N_DENORM + N_OVF + N_ZERO + N_STALL + N_LATENCY;
	localparam int TIMEOUT_NS = N_ITEMS * 20 * 40;

	logic                      clk;
	logic                      rst_n;
	logic                      in_valid;
	logic                      in_ready;
	logic                      in_sign;
	pn_pkg::rmode_t            in_rmode;
	logic [`PN_EXP_W-1:0]      in_exp;
	logic [`PN_FRACT_IN_W-1:0] in_fract;
	logic                      out_valid;
	logic                      out_ready;
	logic [31:0]               out_result;
	logic                      out_overflow;
	logic                      out_underflow;
	logic                      out_inexact;

	integer      seed;
	integer      ready_seed;
	logic [31:0] ready_bits;
	logic        random_ready;
	logic        latency_check;
	int          cycle_count;
	int          accepted_count;
	int          acc_cycle;
	logic [34:0] want;
	logic [34:0] expected_q[$];
	int          accept_cycle_q[$];

	`include "pn_ref_model.svh"

	pn_top dut0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.in_sign       (in_sign),
		.in_rmode      (in_rmode),
		.in_exp        (in_exp),
		.in_fract      (in_fract),
		.out_valid     (out_valid),
		.out_ready     (out_ready),
		.out_result    (out_result),
		.out_overflow  (out_overflow),
		.out_underflow (out_underflow),
		.out_inexact   (out_inexact)
	);

	always #20 clk = ~clk;

	// ----------------------------------------------------------
	// Helpers

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp_val,
		input string what);
		if (got !== exp_val)
		begin
			$display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp_val);
			$display("TEST FAILED");
			$fatal(1, "Mismatch on %s", what);
		end
	endtask

	function automatic logic [31:0] rand32();
		logic [31:0] r;

		r = $random(seed);
		return r;
	endfunction

	function automatic logic [47:0] rand_fract();
		logic [31:0] hi;
		logic [31:0] lo;

		hi = rand32();
		lo = rand32();
		return {hi[15:0], lo};
	endfunction

	// Holds the item on the inputs until the DUT takes it
	task automatic send_item(input logic s, input pn_pkg::rmode_t rm,
		input logic [7:0] e, input logic [47:0] f);
		int target;

		target   = accepted_count + 1;
		in_valid = 1'b1;
		in_sign  = s;
		in_rmode = rm;
		in_exp   = e;
		in_fract = f;
		@(posedge clk);
		#2;
		while (accepted_count != target)
		begin
			@(posedge clk);
			#2;
		end
		in_valid = 1'b0;
	endtask

	task automatic send_random_mode(input logic [7:0] e, input logic [47:0] f);
		logic [31:0] r;

		r = rand32();
		send_item(r[0], pn_pkg::rmode_t'(r[2:1]), e, f);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic drain();
		while (expected_q.size() != 0)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	// ----------------------------------------------------------
	// Output ready with random stalls when enabled
	initial
	begin
		ready_seed = 32'h94b9_1ca6;
		out_ready  = 1'b1;
		forever
		begin
			@(posedge clk);
			#2;
			ready_bits = $random(ready_seed);
			out_ready  = random_ready ? ready_bits[0] : 1'b1;
		end
	end

	// ----------------------------------------------------------
	// Monitor and scoreboard
	always @(posedge clk)
	begin
		if (rst_n)
		begin
			// Stalls only when all three registers hold an item
			check_value(64'(in_ready), 64'(!(expected_q.size() == 3 && !out_ready)),
				"in_ready");
			if (out_valid && out_ready)
			begin
				if (expected_q.size() == 0)
				begin
					$display("Output transfer at %0t ns with no input waiting for it", $time);
					$display("TEST FAILED");
					$fatal(1, "Unexpected output");
				end
				else
				begin
					want      = expected_q.pop_front();
					acc_cycle = accept_cycle_q.pop_front();
					check_value(64'({out_result, out_overflow, out_underflow, out_inexact}),
						64'(want), "result and flags");
					if (latency_check)
						check_value(64'(cycle_count - acc_cycle), 64'd3, "latency");
				end
			end
			if (in_valid && in_ready)
			begin
				expected_q.push_back(expected_output(in_sign, in_rmode, in_exp, in_fract));
				accept_cycle_q.push_back(cycle_count);
				accepted_count++;
			end
		end
		cycle_count++;
	end

	// Watchdog
	initial
	begin
		#(TIMEOUT_NS);
		$display("Watchdog expired after %0d ns with items still pending", TIMEOUT_NS);
		$display("TEST FAILED");
		$fatal(1, "Timeout");
	end

	// ----------------------------------------------------------
	// Stimulus
	initial
	begin
		seed          = 32'h94b9_1ca6;
		clk           = 1'b0;
		rst_n         = 1'b0;
		in_valid      = 1'b0;
		in_sign       = 1'b0;
		in_rmode      = pn_pkg::RM_NEAREST_EVEN;
		in_exp        = '0;
		in_fract      = '0;
		random_ready  = 1'b0;
		latency_check = 1'b1;

		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		check_value(64'(out_valid), 64'd0, "out_valid after reset");
		check_value(64'(in_ready), 64'd1, "in_ready after reset");

		// Normal operands with the top bit somewhere in 47..44
		for (int n = 0; n < N_NORMAL; n++)
			send_random_mode(8'(2 + rand32() % 250), rand_fract() >> (rand32() % 4));

		// Small exponents and long runs of leading zeros
		for (int n = 0; n < N_DENORM; n++)
		begin
			if (n % 10 == 0)
				send_random_mode(8'd0, 48'h3fff_ffc0_0000);
			else
				send_random_mode(8'(rand32() % 4), rand_fract() >> (rand32() % 48));
		end

		// Top of the exponent range including a rounding carry
		for (int n = 0; n < N_OVF; n++)
		begin
			if (n % 8 == 0)
				send_random_mode(8'd254, 48'h7fff_ffff_ffff);
			else
				send_random_mode(8'(252 + rand32() % 4), rand_fract() | 48'h4000_0000_0000);
		end

		for (int n = 0; n < N_ZERO; n++)
			send_random_mode(8'(rand32()), 48'd0);

		// Random back-pressure with gaps on the input side
		latency_check = 1'b0;
		random_ready  = 1'b1;
		for (int n = 0; n < N_STALL; n++)
		begin
			send_random_mode(8'(rand32()), rand_fract() >> (rand32() % 48));
			if (rand32() % 4 == 0)
				idle_cycles(1);
		end
		random_ready = 1'b0;
		drain();

		// Fixed latency with the output always ready
		latency_check = 1'b1;
		for (int n = 0; n < N_LATENCY; n++)
		begin
			send_random_mode(8'(rand32()), rand_fract() >> (rand32() % 8));
			if (rand32() % 3 == 0)
				idle_cycles(int'(rand32() % 4));
		end
		drain();
		idle_cycles(4);

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+src
+incdir+tests
src/pn_pkg.sv
src/pn_stream_if.sv
src/pn_pipe_reg.sv
src/pn_lzc_stage.sv
src/pn_shift_stage.sv
src/pn_round_stage.sv
src/pn_top.sv
tests/tb_pn_top.sv

/* Makefile */
# Verilator build and run for the post-normalisation unit testbench

VERILATOR ?= verilator
TOP       ?= tb_pn_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FILELIST  ?= sources.f

SRCS := $(wildcard src/*.sv src/*.svh tests/*.sv tests/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
